//--- rtl/board_pkg.sv
package board_pkg;

   // Monochrome tint selected from the board configuration
   // Off keeps the colour picture, the others emulate classic monitors
   typedef enum logic [1:0] {
      mono_off   = 2'd0,
      mono_green = 2'd1,
      mono_amber = 2'd2,
      mono_white = 2'd3
   } mono_mode_t;

   // Active pixels stored per scan line with the 28 MHz master clock
   localparam int default_line_pixels = 448;

endpackage

//--- rtl/line_capture.sv
`timescale 1ns/1ps

module line_capture #(
   parameter int line_pixels = 16
) (
   input  logic              sysclk,
   input  logic              rst_n,
   input  logic              pixel_strobe,
   input  video_pkg::pixel_t pixel,
   input  logic              hsync_n,
   line_mem_if.requester     bus,
   output logic              write_bank,
   output logic              line_start
);
   import video_pkg::*;

   localparam int addr_w = $clog2(line_pixels);
   // The pixel counter saturates at line_pixels
   localparam int cnt_w  = $clog2(line_pixels + 1);

   logic              hsync_d;
   logic [cnt_w-1:0]  count;
   logic              count_en;
   logic              pair_done;
   logic [addr_w-1:0] pair_addr;
   pixel_t            even_pixel;

   // A new line begins on the falling edge of the horizontal sync
   assign line_start = hsync_d & ~hsync_n;

   // Pixels inside the sync pulse and beyond the stored width are dropped
   assign count_en  = pixel_strobe & hsync_n & (count < cnt_w'(line_pixels));
   assign pair_done = count_en & count[0];

   // Bank 1 sits right above bank 0 in the memory
   assign pair_addr = addr_w'(count >> 1) + (write_bank ? addr_w'(line_pixels / 2) : '0);

   // Capture only ever writes
   assign bus.we = 1'b1;

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         hsync_d    <= 1'b1;
         count      <= '0;
         write_bank <= 1'b0;
         bus.req    <= 1'b0;
      end else begin
         hsync_d <= hsync_n;
         // Swap banks so replay can read the line just finished
         if (line_start) begin
            count      <= '0;
            write_bank <= ~write_bank;
         end else if (count_en) begin
            count <= count + 1'b1;
         end
         // The request falls on a cycle without a strobe and is granted at once
         if (pair_done) begin
            bus.req <= 1'b1;
         end else if (bus.gnt) begin
            bus.req <= 1'b0;
         end
      end
   end

   // Even pixel waits here for its odd partner
   // The finished pair and its address are then held for the write
   always_ff @(posedge sysclk) begin
      if (count_en && !count[0]) begin
         even_pixel <= pixel;
      end
      if (pair_done) begin
         bus.addr     <= pair_addr;
         bus.wdata[0] <= even_pixel;
         bus.wdata[1] <= pixel;
      end
   end

endmodule

//--- rtl/line_mem_arbiter.sv
`timescale 1ns/1ps

module line_mem_arbiter #(
   parameter int line_pixels = 16
) (
   input logic sysclk,
   input logic rst_n,
   line_mem_if.arbiter cap,
   line_mem_if.arbiter rep
);
   import video_pkg::*;

   // Two banks of line_pixels/2 pairs each, so line_pixels words in total
   localparam int words  = line_pixels;
   localparam int addr_w = $clog2(words);

   pixel_pair_t       mem [words];
   pixel_pair_t       rd_word;
   logic              access;
   logic              port_we;
   logic [addr_w-1:0] port_addr;
   pixel_pair_t       port_wdata;

   // Capture has fixed priority because the core cannot be stalled
   // It asks at most once every four cycles, so replay still gets
   // three cycles out of four for its one read every two cycles
   assign cap.gnt = cap.req;
   assign rep.gnt = rep.req & ~cap.req;

   // Only one requester is granted per cycle, so one access at most
   assign access = cap.req | rep.req;

   // Route the granted requester to the single memory port
   always_comb begin
      if (cap.req) begin
         port_we    = cap.we;
         port_addr  = cap.addr;
         port_wdata = cap.wdata;
      end else begin
         port_we    = rep.we;
         port_addr  = rep.addr;
         port_wdata = rep.wdata;
      end
   end

   // Memory array write side
   always_ff @(posedge sysclk) begin
      if (access && port_we) begin
         mem[port_addr] <= port_wdata;
      end
   end

   // Registered read port
   // The word appears in the cycle after the granting cycle
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         rd_word <= '0;
      end else if (access && !port_we) begin
         rd_word <= mem[port_addr];
      end
   end

   // Both requesters see the same read register
   // Each one only samples it after a read of its own was granted
   assign cap.rdata = rd_word;
   assign rep.rdata = rd_word;

endmodule

//--- rtl/line_mem_if.sv
`timescale 1ns/1ps

// Port of one requester on the shared single-port line memory
// The requester keeps req, we, addr and wdata steady until gnt is seen high
// The cycle with req and gnt both high performs the access
// Read data shows up on rdata in the cycle after the grant
interface line_mem_if #(
   parameter int addr_w = $clog2(board_pkg::default_line_pixels)
);
   import video_pkg::*;

   logic              req;
   logic              we;
   logic [addr_w-1:0] addr;
   pixel_pair_t       wdata;
   pixel_pair_t       rdata;
   logic              gnt;

   // Line capture and line replay sit on this side
   modport requester (
      output req, we, addr, wdata,
      input  gnt, rdata
   );

   // The memory and its arbiter sit on this side
   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rdata
   );

endinterface

//--- rtl/line_replay.sv
`timescale 1ns/1ps

module line_replay #(
   parameter int line_pixels = 16
) (
   input  logic                            sysclk,
   input  logic                            rst_n,
   input  logic                            line_start,
   input  logic                            write_bank,
   input  logic                            enable_scandoubling,
   input  logic                            scanlines_enable,
   input  video_pkg::pixel_t               bypass_pixel,
   input  logic                            bypass_hsync_n,
   input  logic                            bypass_vsync_n,
   line_mem_if.requester                   bus,
   output logic [video_pkg::out_chan_w-1:0] ro,
   output logic [video_pkg::out_chan_w-1:0] go,
   output logic [video_pkg::out_chan_w-1:0] bo,
   output logic                            hsync,
   output logic                            vsync
);
   import video_pkg::*;

   localparam int half     = line_pixels / 2;
   localparam int sync_len = line_pixels / 4;
   // One output line is the sync pulse followed by the stored pixels
   localparam int pass_len = line_pixels + sync_len;
   localparam int pos_w    = $clog2(pass_len);
   localparam int addr_w   = $clog2(line_pixels);
   localparam int fidx_w   = $clog2(half + 1);

   logic              running;
   logic              second_pass;
   logic              last_pos;
   logic              pass_start;
   logic [pos_w-1:0]  pos;
   logic [pos_w-1:0]  pix_idx;
   logic              in_pixels;
   logic              consume;
   logic              fetching;
   logic              grant;
   logic [fidx_w-1:0] fetch_idx;
   logic [1:0]        fill;
   logic              rd_pend;
   logic [2:0]        slots;
   pixel_pair_t       cur_word;
   pixel_pair_t       pf_word;
   pixel_t            pix;
   logic              dim;
   logic              vsync_line;

   // Bit-repeat a channel to six bits and optionally halve it
   function automatic logic [out_chan_w-1:0] expand(input logic [chan_w-1:0] c,
                                                    input logic halve);
      logic [out_chan_w-1:0] full;
      full = {c, c};
      return halve ? (full >> 1) : full;
   endfunction

   assign last_pos   = pos == pos_w'(pass_len - 1);
   // A pass starts on each input line and again after the first pass
   assign pass_start = line_start | (running & last_pos & ~second_pass);
   assign in_pixels  = pos >= pos_w'(sync_len);
   assign pix_idx    = pos - pos_w'(sync_len);
   // The head word is used up after its odd pixel
   assign consume    = running & in_pixels & pix_idx[0];

   // Words held or in flight after this cycle, which is also the next fill
   assign slots    = {1'b0, fill} + {2'b00, rd_pend} - {2'b00, consume};
   assign fetching = running & (fetch_idx < fidx_w'(half));
   assign grant    = bus.req & bus.gnt;

   // Read the bank capture is not writing, one pair per request
   assign bus.req   = fetching & (slots < 3'd2);
   assign bus.we    = 1'b0;
   assign bus.wdata = '0;
   assign bus.addr  = addr_w'(fetch_idx) + (~write_bank ? addr_w'(half) : '0);

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         running     <= 1'b0;
         second_pass <= 1'b0;
         pos         <= '0;
         vsync_line  <= 1'b1;
      end else begin
         // Vertical sync only changes at an output line boundary
         if (pass_start) begin
            vsync_line <= bypass_vsync_n;
         end
         if (line_start) begin
            running     <= 1'b1;
            second_pass <= 1'b0;
            pos         <= '0;
         end else if (running) begin
            if (last_pos) begin
               pos         <= '0;
               second_pass <= 1'b1;
               // Two passes done, idle until the next input line
               if (second_pass) begin
                  running <= 1'b0;
               end
            end else begin
               pos <= pos + 1'b1;
            end
         end
      end
   end

   // Fetch bookkeeping restarts on every pass
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_idx <= '0;
         fill      <= '0;
         rd_pend   <= 1'b0;
      end else if (pass_start) begin
         fetch_idx <= '0;
         fill      <= '0;
         rd_pend   <= 1'b0;
      end else begin
         rd_pend <= grant;
         fill    <= slots[1:0];
         if (grant) begin
            fetch_idx <= fetch_idx + 1'b1;
         end
      end
   end

   // Head word plus one prefetch word form a two-entry queue
   // The spare entry covers the cycle lost when capture takes the port
   always_ff @(posedge sysclk) begin
      if (rd_pend && consume) begin
         if (fill == 2'd2) begin
            cur_word <= pf_word;
            pf_word  <= bus.rdata;
         end else begin
            cur_word <= bus.rdata;
         end
      end else if (consume) begin
         cur_word <= pf_word;
      end else if (rd_pend) begin
         if (fill == 2'd0) begin
            cur_word <= bus.rdata;
         end else begin
            pf_word <= bus.rdata;
         end
      end
   end

   assign pix = cur_word[pix_idx[0]];
   // Scanline effect darkens the repeated line only
   assign dim = second_pass & scanlines_enable;

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         ro    <= '0;
         go    <= '0;
         bo    <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end else if (enable_scandoubling) begin
         hsync <= ~(running & ~in_pixels);
         vsync <= vsync_line;
         // Black outside the active part of a pass
         ro <= (running && in_pixels) ? expand(pix.r, dim) : '0;
         go <= (running && in_pixels) ? expand(pix.g, dim) : '0;
         bo <= (running && in_pixels) ? expand(pix.b, dim) : '0;
      end else begin
         // TV-rate output passes the tinted stream straight on
         hsync <= bypass_hsync_n;
         vsync <= bypass_vsync_n;
         ro    <= expand(bypass_pixel.r, 1'b0);
         go    <= expand(bypass_pixel.g, 1'b0);
         bo    <= expand(bypass_pixel.b, 1'b0);
      end
   end

endmodule

//--- rtl/monochrome_tint.sv
`timescale 1ns/1ps

module monochrome_tint (
   input  logic                  sysclk,
   input  logic                  rst_n,
   input  logic                  clk14en,
   input  board_pkg::mono_mode_t mode,
   input  video_pkg::pixel_t     pixel_in,
   input  logic                  hsync_in_n,
   input  logic                  vsync_in_n,
   output video_pkg::pixel_t     pixel_out,
   output logic                  hsync_n,
   output logic                  vsync_n,
   output logic                  pixel_strobe
);
   import video_pkg::*;
   import board_pkg::*;

   logic [chan_w+1:0] luma_sum;
   logic [chan_w-1:0] luma;
   pixel_t            tinted;

   // Luma is (red + 2*green + blue) / 4, truncated to three bits
   // The sum needs two extra bits to hold the worst case of 28
   assign luma_sum = {2'b00, pixel_in.r} + {1'b0, pixel_in.g, 1'b0} + {2'b00, pixel_in.b};
   assign luma     = luma_sum[chan_w+1:2];

   always_comb begin
      case (mode)
         mono_green: tinted = '{r: '0, g: luma, b: '0};
         // Amber phosphor is mostly red with some green
         mono_amber: tinted = '{r: luma, g: luma >> 1, b: '0};
         mono_white: tinted = '{r: luma, g: luma, b: luma};
         default:    tinted = pixel_in;
      endcase
   end

   // Pixel and syncs go through the same register on the pixel strobe
   // so they stay aligned, and the strobe itself trails by one cycle
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         pixel_out    <= '0;
         hsync_n      <= 1'b1;
         vsync_n      <= 1'b1;
         pixel_strobe <= 1'b0;
      end else begin
         pixel_strobe <= clk14en;
         if (clk14en) begin
            pixel_out <= tinted;
            hsync_n   <= hsync_in_n;
            vsync_n   <= vsync_in_n;
         end
      end
   end

endmodule

//--- rtl/video_out_top.sv
`timescale 1ns/1ps

module video_out_top #(
   parameter int line_pixels = board_pkg::default_line_pixels
) (
   input  logic                             sysclk,
   input  logic                             rst_n,
   input  logic                             clk14en,
   input  logic                             enable_scandoubling,
   input  logic                             scanlines_enable,
   input  board_pkg::mono_mode_t            monochrome_mode,
   input  logic [video_pkg::chan_w-1:0]     ri,
   input  logic [video_pkg::chan_w-1:0]     gi,
   input  logic [video_pkg::chan_w-1:0]     bi,
   input  logic                             hsync_in_n,
   input  logic                             vsync_in_n,
   output logic [video_pkg::out_chan_w-1:0] ro,
   output logic [video_pkg::out_chan_w-1:0] go,
   output logic [video_pkg::out_chan_w-1:0] bo,
   output logic                             hsync,
   output logic                             vsync
);
   import video_pkg::*;

   pixel_t core_pixel;
   pixel_t tint_pixel;
   logic   tint_hsync_n;
   logic   tint_vsync_n;
   logic   tint_strobe;
   logic   write_bank;
   logic   line_start;

   // One memory port per requester, both served by the arbiter
   line_mem_if #(.addr_w($clog2(line_pixels))) cap_bus ();
   line_mem_if #(.addr_w($clog2(line_pixels))) rep_bus ();

   assign core_pixel = {ri, gi, bi};

   monochrome_tint u_tint (
      .sysclk       (sysclk),
      .rst_n        (rst_n),
      .clk14en      (clk14en),
      .mode         (monochrome_mode),
      .pixel_in     (core_pixel),
      .hsync_in_n   (hsync_in_n),
      .vsync_in_n   (vsync_in_n),
      .pixel_out    (tint_pixel),
      .hsync_n      (tint_hsync_n),
      .vsync_n      (tint_vsync_n),
      .pixel_strobe (tint_strobe)
   );

   line_capture #(.line_pixels(line_pixels)) u_capture (
      .sysclk       (sysclk),
      .rst_n        (rst_n),
      .pixel_strobe (tint_strobe),
      .pixel        (tint_pixel),
      .hsync_n      (tint_hsync_n),
      .bus          (cap_bus.requester),
      .write_bank   (write_bank),
      .line_start   (line_start)
   );

   line_replay #(.line_pixels(line_pixels)) u_replay (
      .sysclk              (sysclk),
      .rst_n               (rst_n),
      .line_start          (line_start),
      .write_bank          (write_bank),
      .enable_scandoubling (enable_scandoubling),
      .scanlines_enable    (scanlines_enable),
      .bypass_pixel        (tint_pixel),
      .bypass_hsync_n      (tint_hsync_n),
      .bypass_vsync_n      (tint_vsync_n),
      .bus                 (rep_bus.requester),
      .ro                  (ro),
      .go                  (go),
      .bo                  (bo),
      .hsync               (hsync),
      .vsync               (vsync)
   );

   line_mem_arbiter #(.line_pixels(line_pixels)) u_arbiter (
      .sysclk (sysclk),
      .rst_n  (rst_n),
      .cap    (cap_bus.arbiter),
      .rep    (rep_bus.arbiter)
   );

endmodule

//--- rtl/video_pkg.sv
package video_pkg;

   // Bits per colour channel as the core delivers them
   localparam int chan_w = 3;

   // The VGA resistor DAC takes six bits per channel
   // Each output channel repeats the three input bits twice
   localparam int out_chan_w = 2 * chan_w;

   // One core pixel with red in the top bits and blue in the bottom bits
   typedef struct packed {
      logic [chan_w-1:0] r;
      logic [chan_w-1:0] g;
      logic [chan_w-1:0] b;
   } pixel_t;

   // Two horizontally adjacent pixels
   // Element 0 is the even pixel, which is the left one on screen
   // This pair is also the word stored in the line memory
   typedef pixel_t [1:0] pixel_pair_t;

endpackage

//--- sources.f
rtl/video_pkg.sv
rtl/board_pkg.sv
rtl/line_mem_if.sv
rtl/line_mem_arbiter.sv
rtl/monochrome_tint.sv
rtl/line_capture.sv
rtl/line_replay.sv
rtl/video_out_top.sv
testbench/video_out_properties.sv
testbench/tb_video_out.sv

//--- testbench/tb_video_out.sv
`timescale 1ns/1ps

module tb_video_out;
   import video_pkg::*;
   import board_pkg::*;

   localparam int line_pixels = 16;
   localparam int sync_slots  = 4;

   logic                  sysclk;
   logic                  rst_n;
   logic                  clk14en;
   logic                  enable_scandoubling;
   logic                  scanlines_enable;
   mono_mode_t            monochrome_mode;
   logic [chan_w-1:0]     ri;
   logic [chan_w-1:0]     gi;
   logic [chan_w-1:0]     bi;
   logic                  hsync_in_n;
   logic                  vsync_in_n;
   logic [out_chan_w-1:0] ro;
   logic [out_chan_w-1:0] go;
   logic [out_chan_w-1:0] bo;
   logic                  hsync;
   logic                  vsync;

   // Tinted pixels of every finished input line, oldest line first
   pixel_t      ref_q[$];
   logic [31:0] lfsr_state;
   logic        check_doubled;
   logic        bypass_check;
   logic        prev_valid;
   pixel_t      prev_exp;
   logic        prev_hs;
   logic        prev_vs;
   logic        mon_active;
   logic        mon_second;
   logic        hsync_seen;
   int          mon_idx;
   int          checked_passes;
   int          dim_passes;
   int          bypass_checks;

   video_out_top #(.line_pixels(line_pixels)) u_dut (.*);

   always #5 sysclk = ~sysclk;

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      stop_with_failure($sformatf("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp));
   endtask

   // Galois LFSR, one step per random bit
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   task automatic take_bits(input int n, output logic [8:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits       = {bits[7:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Monochrome rule with luma = (r + 2g + b) / 4 in whole numbers
   function automatic pixel_t tint_ref(input pixel_t p, input mono_mode_t m);
      int     y;
      pixel_t t;
      y = (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
      case (m)
         mono_green: t = '{r: 3'd0, g: 3'(y), b: 3'd0};
         mono_amber: t = '{r: 3'(y), g: 3'(y / 2), b: 3'd0};
         mono_white: t = '{r: 3'(y), g: 3'(y), b: 3'(y)};
         default:    t = p;
      endcase
      return t;
   endfunction

   // Six-bit DAC value from a three-bit channel, halved for a dark scanline
   function automatic logic [out_chan_w-1:0] to_out(input logic [chan_w-1:0] c, input logic dim);
      logic [out_chan_w-1:0] v;
      v = {c, c};
      if (dim) begin
         v = v / 2;
      end
      return v;
   endfunction

   // One pixel slot is two sysclk cycles with clk14en high in the first
   // In bypass the previous slot's pixel is on the outputs by now
   task automatic drive_slot(input pixel_t p, input logic hs_n, input logic vs_n);
      @(negedge sysclk);
      if (bypass_check && prev_valid) begin
         assert (ro == to_out(prev_exp.r, 1'b0)) else report_mismatch("ro", ro, to_out(prev_exp.r, 1'b0));
         assert (go == to_out(prev_exp.g, 1'b0)) else report_mismatch("go", go, to_out(prev_exp.g, 1'b0));
         assert (bo == to_out(prev_exp.b, 1'b0)) else report_mismatch("bo", bo, to_out(prev_exp.b, 1'b0));
         assert (hsync == prev_hs) else report_mismatch("hsync", hsync, prev_hs);
         assert (vsync == prev_vs) else report_mismatch("vsync", vsync, prev_vs);
         bypass_checks++;
      end
      {ri, gi, bi} = p;
      hsync_in_n   = hs_n;
      vsync_in_n   = vs_n;
      clk14en      = 1'b1;
      prev_exp     = tint_ref(p, monochrome_mode);
      prev_hs      = hs_n;
      prev_vs      = vs_n;
      prev_valid   = 1'b1;
      @(negedge sysclk);
      clk14en = 1'b0;
   endtask

   // Random active pixels followed by the horizontal sync pulse
   task automatic drive_line(input logic vs_n);
      pixel_t     line_buf [line_pixels];
      logic [8:0] bits;
      for (int i = 0; i < line_pixels; i++) begin
         take_bits(9, bits);
         line_buf[i] = bits;
         drive_slot(line_buf[i], 1'b1, vs_n);
      end
      // The finished line becomes the reference for its replay
      for (int i = 0; i < line_pixels; i++) begin
         ref_q.push_back(tint_ref(line_buf[i], monochrome_mode));
      end
      for (int i = 0; i < sync_slots; i++) begin
         drive_slot('0, 1'b0, vs_n);
      end
   endtask

   // Only the last line, which is never fully replayed, may stay queued
   task automatic wait_replay_drain();
      int cycles;
      cycles = 0;
      while (ref_q.size() > line_pixels) begin
         @(negedge sysclk);
         cycles++;
         if (cycles > 200) begin
            stop_with_failure("the stored lines were not replayed in time");
         end
      end
   endtask

   // Each output pass is checked from the end of its hsync pulse
   // The first pass of a line shows it plain, the second may be darkened
   always @(negedge sysclk) begin : doubled_monitor
      pixel_t exp_p;
      logic   dim;
      if (!check_doubled) begin
         mon_active = 1'b0;
      end else begin
         if (!mon_active && !hsync_seen && hsync && ref_q.size() >= line_pixels) begin
            mon_active = 1'b1;
            mon_idx    = 0;
         end
         if (mon_active) begin
            exp_p = ref_q[mon_idx];
            dim   = mon_second && scanlines_enable;
            assert (hsync == 1'b1) else report_mismatch("hsync", hsync, 1);
            assert (vsync == 1'b1) else report_mismatch("vsync", vsync, 1);
            assert (ro == to_out(exp_p.r, dim)) else report_mismatch("ro", ro, to_out(exp_p.r, dim));
            assert (go == to_out(exp_p.g, dim)) else report_mismatch("go", go, to_out(exp_p.g, dim));
            assert (bo == to_out(exp_p.b, dim)) else report_mismatch("bo", bo, to_out(exp_p.b, dim));
            mon_idx++;
            if (mon_idx == line_pixels) begin
               mon_active = 1'b0;
               checked_passes++;
               if (dim) begin
                  dim_passes++;
               end
               // Both passes of the line are done
               if (mon_second) begin
                  repeat (line_pixels) void'(ref_q.pop_front());
               end
               mon_second = !mon_second;
            end
         end
      end
      hsync_seen = hsync;
   end

   // A bound property failure ends the run at once
   always @(posedge u_dut.u_props.violation) begin
      stop_with_failure("a bound assertion on the DUT failed");
   end

   initial begin
      sysclk              = 1'b0;
      rst_n               = 1'b0;
      clk14en             = 1'b0;
      enable_scandoubling = 1'b1;
      scanlines_enable    = 1'b0;
      monochrome_mode     = mono_off;
      ri                  = '0;
      gi                  = '0;
      bi                  = '0;
      hsync_in_n          = 1'b1;
      vsync_in_n          = 1'b1;
      lfsr_state          = 32'd70135;
      check_doubled       = 1'b1;
      bypass_check        = 1'b0;
      prev_valid          = 1'b0;
      mon_active          = 1'b0;
      mon_second          = 1'b0;
      hsync_seen          = 1'b1;
      mon_idx             = 0;
      checked_passes      = 0;
      dim_passes          = 0;
      bypass_checks       = 0;
      repeat (5) @(negedge sysclk);
      rst_n = 1'b1;
      // Nothing is replayed before the first line
      repeat (10) begin
         @(negedge sysclk);
         assert (hsync == 1'b1) else report_mismatch("hsync", hsync, 1);
         assert (vsync == 1'b1) else report_mismatch("vsync", vsync, 1);
         assert (ro == '0) else report_mismatch("ro", ro, 0);
         assert (go == '0) else report_mismatch("go", go, 0);
         assert (bo == '0) else report_mismatch("bo", bo, 0);
      end
      // An opening sync pulse aligns capture with the first line
      for (int i = 0; i < sync_slots; i++) begin
         drive_slot('0, 1'b0, 1'b1);
      end
      repeat (3) drive_line(1'b1);
      // Set during a line, this darkens the second pass of the line before
      scanlines_enable = 1'b1;
      repeat (2) drive_line(1'b1);
      scanlines_enable = 1'b0;
      monochrome_mode  = mono_green;
      drive_line(1'b1);
      monochrome_mode = mono_amber;
      drive_line(1'b1);
      monochrome_mode = mono_white;
      drive_line(1'b1);
      // This line carries the white line through its replay
      monochrome_mode = mono_off;
      drive_line(1'b1);
      wait_replay_drain();
      // TV-rate section with a tint and a vertical sync line
      check_doubled       = 1'b0;
      enable_scandoubling = 1'b0;
      bypass_check        = 1'b1;
      prev_valid          = 1'b0;
      monochrome_mode     = mono_amber;
      drive_line(1'b1);
      monochrome_mode = mono_off;
      drive_line(1'b0);
      drive_slot('0, 1'b1, 1'b1);
      if (checked_passes < 16) begin
         stop_with_failure("fewer scan-doubled passes were checked than lines were sent");
      end else if (dim_passes == 0) begin
         stop_with_failure("no darkened second pass was checked");
      end else if (bypass_checks == 0) begin
         stop_with_failure("no bypass pixel was checked");
      end else if (u_dut.u_props.violation) begin
         stop_with_failure("a bound assertion on the DUT failed");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

//--- testbench/video_out_properties.sv
`timescale 1ns/1ps

module video_out_properties (
   input logic                             sysclk,
   input logic                             rst_n,
   input logic                             cap_req,
   input logic                             cap_gnt,
   input logic                             rep_req,
   input logic                             rep_gnt,
   input logic                             hsync,
   input logic                             vsync,
   input logic [video_pkg::out_chan_w-1:0] ro,
   input logic [video_pkg::out_chan_w-1:0] go,
   input logic [video_pkg::out_chan_w-1:0] bo
);

   // Goes high once any property below has failed
   logic violation;

   initial violation = 1'b0;

   // The core cannot be stalled, so a capture write is granted in its own cycle
   cap_never_refused: assert property (
      @(posedge sysclk) disable iff (!rst_n) cap_req |-> cap_gnt
   ) else begin
      $error("line capture asked for the memory and was not granted");
      violation = 1'b1;
   end

   // The single memory port serves one requester per cycle
   single_grant: assert property (
      @(posedge sysclk) disable iff (!rst_n) !(cap_gnt && rep_gnt)
   ) else begin
      $error("capture and replay were granted the memory in the same cycle");
      violation = 1'b1;
   end

   // Syncs idle high and no requester asks while reset is held
   reset_idle: assert property (
      @(posedge sysclk) !rst_n |=> hsync && vsync && !cap_req && !rep_req
   ) else begin
      $error("syncs or memory requests were not idle during reset");
      violation = 1'b1;
   end

   // The picture starts black with inactive syncs when reset is released
   release_idle: assert property (
      @(posedge sysclk) $rose(rst_n) |-> hsync && vsync && ro == '0 && go == '0 && bo == '0
   ) else begin
      $error("outputs were not idle when reset was released");
      violation = 1'b1;
   end

endmodule

bind video_out_top video_out_properties u_props (
   .sysclk  (sysclk),
   .rst_n   (rst_n),
   .cap_req (cap_bus.req),
   .cap_gnt (cap_bus.gnt),
   .rep_req (rep_bus.req),
   .rep_gnt (rep_bus.gnt),
   .hsync   (hsync),
   .vsync   (vsync),
   .ro      (ro),
   .go      (go),
   .bo      (bo)
);
